// File: dv/router_checker.sv
module router_checker
#(
    parameter noc_pkg::coord_t node_x = 2'd1,
    parameter noc_pkg::coord_t node_y = 2'd1
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  noc_pkg::port_vec_t in_wr,
    input  noc_pkg::flit_t     in_flit [noc_pkg::num_ports],
    input  noc_pkg::port_vec_t in_full,
    input  noc_pkg::flit_t     out_flit [noc_pkg::num_ports],
    input  noc_pkg::port_vec_t out_valid,
    input  logic               check_latency,
    input  logic               check_fair,
    output int                 pending,
    output int                 error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n = noc_pkg::num_ports;

    // One queue per flow, index is source * n + output
    noc_pkg::flit_t flow_q [n*n][$];
    // Edge number at which each queued flit was written
    int edge_q [n*n][$];
    int edge_count = 0;
    // Per output and source, grants to others since that source was last served
    int others_served [n][n];
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_mark = 0;

    initial
    begin
        pending     = 0;
        error_count = 0;
    end

    // XY reference, X first, east and north increasing
    function automatic noc_pkg::dir_t xy_route(input noc_pkg::flit_t f);
        int dx;
        int dy;
        dx = f[15:14];
        dy = f[13:12];
        if (dx > int'(node_x))
            return noc_pkg::dir_east;
        if (dx < int'(node_x))
            return noc_pkg::dir_west;
        if (dy > int'(node_y))
            return noc_pkg::dir_north;
        if (dy < int'(node_y))
            return noc_pkg::dir_south;
        return noc_pkg::dir_local;
    endfunction

    ////////////////////////////////////////////////////////////////////////////////
    // Output compare, source port sits in payload bits 11:9
    ////////////////////////////////////////////////////////////////////////////////

    task automatic check_output(input int o);
        int src;
        int q;
        int lat;
        noc_pkg::flit_t exp_flit;
        src = out_flit[o][11:9];
        checks++;
        if (src >= n)
        begin
            $display("Flit %h on output %0d names unknown source %0d at %0t",
                     out_flit[o], o, src, $time);
            error_count++;
            return;
        end
        q = src * n + o;
        if (flow_q[q].size() == 0)
        begin
            $display("Unexpected flit %h on output %0d from input %0d at %0t",
                     out_flit[o], o, src, $time);
            error_count++;
            return;
        end
        exp_flit = flow_q[q].pop_front();
        // Registered one edge before the edge that samples it
        lat = edge_count - 1 - edge_q[q].pop_front();
        pending--;
        if (out_flit[o] !== exp_flit)
        begin
            $display("** Error at %0t: out_flit[%0d] = %h, expected %h",
                     $time, o, out_flit[o], exp_flit);
            error_count++;
        end
        if (check_latency && lat != 2)
        begin
            $display("** Error at %0t: out_valid[%0d] latency = %0d, expected 2",
                     $time, o, lat);
            error_count++;
        end
        // Four requesters in rotation, so three others at most
        if (check_fair && others_served[o][src] > 3)
        begin
            $display("Unfair arbitration: input %0d waited %0d grants on output %0d at %0t",
                     src, others_served[o][src], o, $time);
            error_count++;
        end
        for (int s = 0; s < n; s++)
            others_served[o][s] = (s == src) ? 0 : others_served[o][s] + 1;
    endtask

    // Outputs first, then accepted writes of the same edge
    always @(posedge clk)
    begin
        int q;
        if (!rst_n)
        begin
            edge_count++;
            for (int o = 0; o < n; o++)
            begin
                if (out_valid[o])
                    check_output(o);
                if (!check_fair)
                begin
                    for (int s = 0; s < n; s++)
                        others_served[o][s] = 0;
                end
            end
            for (int d = 0; d < n; d++)
            begin
                if (in_wr[d] && !in_full[d])
                begin
                    q = d * n + int'(xy_route(in_flit[d]));
                    flow_q[q].push_back(in_flit[d]);
                    edge_q[q].push_back(edge_count);
                    pending++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////////
    // Test bookkeeping
    ////////////////////////////////////////////////////////////////////////////////

    task automatic check_idle();
        checks++;
        if (out_valid !== '0)
        begin
            $display("** Error at %0t: out_valid = %b, expected %b", $time, out_valid, 5'b0);
            error_count++;
        end
        if (in_full !== '0)
        begin
            $display("** Error at %0t: in_full = %b, expected %b", $time, in_full, 5'b0);
            error_count++;
        end
    endtask

    task automatic end_test(input string name);
        if (pending != 0)
        begin
            $display("%0d accepted flits never left the router", pending);
            error_count++;
        end
        tests_run++;
        if (error_count != test_mark)
            tests_failed++;
        $display("Test %-14s %s, %0d errors", name,
                 (error_count == test_mark) ? "ok" : "FAILED", error_count - test_mark);
        test_mark = error_count;
    endtask

    task automatic summary();
        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, error_count);
    endtask

endmodule

// File: dv/tb_router.sv
module tb_router;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles  = 16;
    localparam int drain_allow   = 80;
    localparam int stream_len    = 8;
    localparam int contend_len   = 40;
    localparam int overflow_hold = 6;
    localparam int random_len    = 400;
    // Nine drains plus the overflow fill, which the buffer depth bounds
    localparam int sched_cycles = reset_cycles + stream_len + contend_len
        + noc_pkg::fifo_depth + overflow_hold + random_len + 9 * drain_allow;
    localparam int cycle_limit = 2 * sched_cycles + 200;

    logic               clk;
    logic               rst_n;
    noc_pkg::port_vec_t in_wr;
    noc_pkg::flit_t     in_flit [noc_pkg::num_ports];
    noc_pkg::port_vec_t in_full;
    noc_pkg::flit_t     out_flit [noc_pkg::num_ports];
    noc_pkg::port_vec_t out_valid;
    logic               check_latency;
    logic               check_fair;
    int                 pending;
    int                 error_count;
    int                 cycle = 0;
    logic [31:0]        rng;
    // Per source sequence number below the source field
    logic [8:0]         seq [noc_pkg::num_ports];

    router_node #(.node_x(2'd1), .node_y(2'd1)) DUT
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_wr     (in_wr),
        .in_flit   (in_flit),
        .in_full   (in_full),
        .out_flit  (out_flit),
        .out_valid (out_valid)
    );

    router_checker #(.node_x(2'd1), .node_y(2'd1)) u_chk
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_wr         (in_wr),
        .in_flit       (in_flit),
        .in_full       (in_full),
        .out_flit      (out_flit),
        .out_valid     (out_valid),
        .check_latency (check_latency),
        .check_fair    (check_fair),
        .pending       (pending),
        .error_count   (error_count)
    );

    initial
        clk = 1'b0;
    always #10 clk = ~clk;

    // Watchdog
    always @(posedge clk)
    begin
        cycle++;
        if (cycle >= cycle_limit)
        begin
            $display("Timeout: run passed the limit of %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Offer one flit on a port for the coming edge
    task automatic offer(input int port, input noc_pkg::coord_t dx, input noc_pkg::coord_t dy);
        in_wr[port]   = 1'b1;
        in_flit[port] = {dx, dy, 3'(port), seq[port]};
        seq[port]     = seq[port] + 1'b1;
    endtask

    // Stop writing and give the scoreboard a bounded time to empty
    task automatic drain();
        int waited;
        in_wr  = '0;
        waited = 0;
        while (pending != 0 && waited < drain_allow)
        begin
            @(negedge clk);
            waited++;
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic send_single(input noc_pkg::coord_t dx, input noc_pkg::coord_t dy);
        offer(noc_pkg::dir_local, dx, dy);
        @(negedge clk);
        drain();
    endtask

    initial
    begin
        rng           = 32'h3d1c;
        in_wr         = '0;
        check_latency = 1'b0;
        check_fair    = 1'b0;
        for (int d = 0; d < noc_pkg::num_ports; d++)
        begin
            in_flit[d] = '0;
            seq[d]     = '0;
        end
        rst_n = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b0;
        @(negedge clk);
        u_chk.check_idle();
        u_chk.end_test("reset");

        // Local, north, east, south, west from node (1,1)
        check_latency = 1'b1;
        send_single(2'd1, 2'd1);
        send_single(2'd1, 2'd2);
        send_single(2'd2, 2'd1);
        send_single(2'd1, 2'd0);
        send_single(2'd0, 2'd1);
        u_chk.end_test("single");

        // West input streaming east
        for (int k = 0; k < stream_len; k++)
        begin
            offer(noc_pkg::dir_west, 2'd3, 2'd1);
            @(negedge clk);
        end
        drain();
        check_latency = 1'b0;
        u_chk.end_test("stream");

        // Four neighbours fighting for local
        check_fair = 1'b1;
        for (int k = 0; k < contend_len; k++)
        begin
            for (int d = 1; d < noc_pkg::num_ports; d++)
                offer(d, 2'd1, 2'd1);
            @(negedge clk);
        end
        drain();
        check_fair = 1'b0;
        u_chk.end_test("contention");

        // All inputs push toward local until a buffer fills and beyond
        while (in_full == '0)
        begin
            for (int d = 0; d < noc_pkg::num_ports; d++)
                offer(d, 2'd1, 2'd1);
            @(negedge clk);
        end
        repeat (overflow_hold)
        begin
            for (int d = 0; d < noc_pkg::num_ports; d++)
                offer(d, 2'd1, 2'd1);
            @(negedge clk);
        end
        drain();
        u_chk.end_test("overflow");

        // Each port writes three cycles in four to a random destination
        repeat (random_len)
        begin
            in_wr = '0;
            for (int d = 0; d < noc_pkg::num_ports; d++)
            begin
                rng = xorshift(rng);
                if (rng[1:0] != 2'b00)
                    offer(d, rng[9:8], rng[11:10]);
            end
            @(negedge clk);
        end
        drain();
        u_chk.end_test("random");

        u_chk.summary();
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: files.f
source/noc_pkg.sv
source/port_fifo.sv
source/input_port.sv
source/rr_arbiter.sv
source/switch_allocator.sv
source/router_node.sv
dv/router_checker.sv
dv/tb_router.sv

// File: source/input_port.sv
module input_port
#(
    parameter noc_pkg::coord_t node_x = 2'd1,
    parameter noc_pkg::coord_t node_y = 2'd1
)
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           wr_en,
    input  noc_pkg::flit_t flit_in,
    output logic           full,
    input  logic           grant,
    output logic           req,
    output noc_pkg::dir_t  req_dir,
    output noc_pkg::flit_t head_flit
);

    logic fifo_empty;
    logic rd_en;
    // Head register holds a flit waiting for the switch
    logic head_valid;

    // Destination fields of the head flit
    noc_pkg::coord_t dst_x;
    noc_pkg::coord_t dst_y;

    // Prefetch when the head slot is free or being freed this cycle
    assign rd_en = !fifo_empty && (!head_valid || grant);

    // FIFO read register doubles as the head register
    port_fifo u_fifo
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .fifo_in  (flit_in),
        .fifo_out (head_flit),
        .empty    (fifo_empty),
        .full     (full)
    );

    // Head valid flag, refilled at the edge of a grant without a bubble
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            head_valid <= 1'b0;
        else if (rd_en)
            head_valid <= 1'b1;
        else if (grant)
            head_valid <= 1'b0;
    end

    assign req = head_valid;

    ////////////////////////////////////////////////////////////////////////////
    // XY routing, X first, east and north are increasing
    ////////////////////////////////////////////////////////////////////////////

    assign dst_x = head_flit[noc_pkg::flit_w-1 -: noc_pkg::coord_w];
    assign dst_y = head_flit[noc_pkg::flit_w-1-noc_pkg::coord_w -: noc_pkg::coord_w];

    always_comb
    begin
        if (dst_x > node_x)
            req_dir = noc_pkg::dir_east;
        else if (dst_x < node_x)
            req_dir = noc_pkg::dir_west;
        else if (dst_y > node_y)
            req_dir = noc_pkg::dir_north;
        else if (dst_y < node_y)
            req_dir = noc_pkg::dir_south;
        else
            req_dir = noc_pkg::dir_local;
    end

    // Allocator may only grant a valid head
    a_grant_needs_req: assert property (@(posedge clk) disable iff (rst_n)
        grant |-> req);

endmodule

// File: source/noc_pkg.sv
package noc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Mesh and flit sizes
    ////////////////////////////////////////////////////////////////////////////

    // Five directions per node, local included
    localparam int num_ports = 5;

    // 4 by 4 mesh, so two bits per coordinate
    localparam int coord_w = 2;

    // Payload below the destination field
    localparam int payload_w = 12;

    // Destination X on top, destination Y next, then payload
    localparam int flit_w = 2 * coord_w + payload_w;

    // Input buffer entries per direction
    localparam int fifo_depth = 8;
    localparam int ptr_w = $clog2(fifo_depth);

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [coord_w-1:0] coord_t;
    typedef logic [flit_w-1:0] flit_t;
    typedef logic [ptr_w-1:0] ptr_t;
    // One extra bit so a full buffer still fits
    typedef logic [ptr_w:0] count_t;
    typedef logic [num_ports-1:0] port_vec_t;

    // Output direction, also the port index
    typedef enum logic [2:0]
    {
        dir_local = 3'd0,
        dir_north = 3'd1,
        dir_east  = 3'd2,
        dir_south = 3'd3,
        dir_west  = 3'd4
    } dir_t;

endpackage

// File: source/port_fifo.sv
module port_fifo
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           wr_en,
    input  logic           rd_en,
    input  noc_pkg::flit_t fifo_in,
    output noc_pkg::flit_t fifo_out,
    output logic           empty,
    output logic           full
);

    ////////////////////////////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////////////////////////////

    // Circular buffer, one flit per entry
    noc_pkg::flit_t mem [noc_pkg::fifo_depth];

    // Pointers wrap on their own, depth is a power of two
    noc_pkg::ptr_t wr_ptr;
    noc_pkg::ptr_t rd_ptr;

    // Occupancy, reaches fifo_depth when full
    noc_pkg::count_t count;

    // Strobes after the flag checks
    logic wr_ok;
    logic rd_ok;

    // Write dropped when full, read ignored when empty
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // Flags straight from the counter
    assign empty = (count == '0);
    assign full  = (count == noc_pkg::count_t'(noc_pkg::fifo_depth));

    // Occupancy counter
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            count <= '0;
        else
        begin
            case ({wr_ok, rd_ok})
                // Push only
                2'b10:   count <= count + 1'b1;
                // Pop only
                2'b01:   count <= count - 1'b1;
                // Both or neither, level unchanged
                default: count <= count;
            endcase
        end
    end

    // Pointer advance
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_ok)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Buffer write
    always_ff @(posedge clk)
    begin
        if (wr_ok)
            mem[wr_ptr] <= fifo_in;
    end

    // Registered read data, holds between pops
    always_ff @(posedge clk)
    begin
        if (rd_ok)
            fifo_out <= mem[rd_ptr];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_count_bound: assert property (@(posedge clk) disable iff (rst_n)
        count <= noc_pkg::count_t'(noc_pkg::fifo_depth));

    // Prefetch logic upstream must never pop an empty buffer
    a_no_read_empty: assert property (@(posedge clk) disable iff (rst_n)
        !(rd_en && empty));

endmodule

// File: source/router_node.sv
module router_node
#(
    parameter noc_pkg::coord_t node_x = 2'd1,
    parameter noc_pkg::coord_t node_y = 2'd1
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  noc_pkg::port_vec_t in_wr,
    input  noc_pkg::flit_t     in_flit [noc_pkg::num_ports],
    output noc_pkg::port_vec_t in_full,
    output noc_pkg::flit_t     out_flit [noc_pkg::num_ports],
    output noc_pkg::port_vec_t out_valid
);

    ////////////////////////////////////////////////////////////////////////////
    // Input side to allocator
    ////////////////////////////////////////////////////////////////////////////

    // Head valid per input
    noc_pkg::port_vec_t req;
    // XY result per input
    noc_pkg::dir_t      req_dir [noc_pkg::num_ports];
    // Head flit per input
    noc_pkg::flit_t     head_flit [noc_pkg::num_ports];
    // Head consumed this cycle
    noc_pkg::port_vec_t grant;

    // Port index d follows dir_t, local first
    for (genvar d = 0; d < noc_pkg::num_ports; d++)
    begin : g_in
        input_port
        #(
            .node_x (node_x),
            .node_y (node_y)
        )
        u_in
        (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_en     (in_wr[d]),
            .flit_in   (in_flit[d]),
            .full      (in_full[d]),
            .grant     (grant[d]),
            .req       (req[d]),
            .req_dir   (req_dir[d]),
            .head_flit (head_flit[d])
        );
    end

    // Arbitration and registered crossbar
    switch_allocator u_alloc
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_dir   (req_dir),
        .head_flit (head_flit),
        .grant     (grant),
        .out_flit  (out_flit),
        .out_valid (out_valid)
    );

endmodule

// File: source/rr_arbiter.sv
module rr_arbiter
(
    input  logic               clk,
    input  logic               rst_n,
    input  noc_pkg::port_vec_t req,
    output noc_pkg::port_vec_t grant
);

    // Index of the last winner
    noc_pkg::dir_t last;
    // Index picked this cycle
    noc_pkg::dir_t win;

    ////////////////////////////////////////////////////////////////////////////
    // Rotating search
    ////////////////////////////////////////////////////////////////////////////

    // Start after the last winner, wrap, first requester wins
    always_comb
    begin
        int idx;
        logic found;

        grant = '0;
        win   = last;
        found = 1'b0;
        for (int i = 1; i <= noc_pkg::num_ports; i++)
        begin
            idx = (int'(last) + i) % noc_pkg::num_ports;
            if (!found && req[idx])
            begin
                grant[idx] = 1'b1;
                win        = noc_pkg::dir_t'(idx);
                found      = 1'b1;
            end
        end
    end

    // Pointer moves only on a grant
    // Reset to west so local wins first
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            last <= noc_pkg::dir_west;
        else if (|grant)
            last <= win;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_grant_legal: assert property (@(posedge clk) disable iff (rst_n)
        $onehot0(grant) && ((grant & ~req) == '0));

endmodule

// File: source/switch_allocator.sv
module switch_allocator
(
    input  logic               clk,
    input  logic               rst_n,
    input  noc_pkg::port_vec_t req,
    input  noc_pkg::dir_t      req_dir [noc_pkg::num_ports],
    input  noc_pkg::flit_t     head_flit [noc_pkg::num_ports],
    output noc_pkg::port_vec_t grant,
    output noc_pkg::flit_t     out_flit [noc_pkg::num_ports],
    output noc_pkg::port_vec_t out_valid
);

    // Per output, which inputs want it
    noc_pkg::port_vec_t out_req [noc_pkg::num_ports];
    // Per output, which input it serves
    noc_pkg::port_vec_t out_grant [noc_pkg::num_ports];
    // Winning head per output, before the output register
    noc_pkg::flit_t sel_flit [noc_pkg::num_ports];
    // Inputs claimed by more than one output
    noc_pkg::port_vec_t multi_grant;

    ////////////////////////////////////////////////////////////////////////////
    // Request steering and arbitration
    ////////////////////////////////////////////////////////////////////////////

    // Valid head routed to output o requests o
    always_comb
    begin
        for (int o = 0; o < noc_pkg::num_ports; o++)
        begin
            for (int i = 0; i < noc_pkg::num_ports; i++)
                out_req[o][i] = req[i] && (req_dir[i] == noc_pkg::dir_t'(o));
        end
    end

    for (genvar o = 0; o < noc_pkg::num_ports; o++)
    begin : g_arb
        rr_arbiter u_arb
        (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (out_req[o]),
            .grant (out_grant[o])
        );
    end

    // Fold output grants back onto the inputs
    always_comb
    begin
        grant       = '0;
        multi_grant = '0;
        for (int o = 0; o < noc_pkg::num_ports; o++)
        begin
            multi_grant = multi_grant | (grant & out_grant[o]);
            grant       = grant | out_grant[o];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Crossbar and output register
    ////////////////////////////////////////////////////////////////////////////

    // One-hot select of the winning head
    always_comb
    begin
        for (int o = 0; o < noc_pkg::num_ports; o++)
        begin
            sel_flit[o] = '0;
            for (int i = 0; i < noc_pkg::num_ports; i++)
            begin
                if (out_grant[o][i])
                    sel_flit[o] = head_flit[i];
            end
        end
    end

    // Valid strobe lasts one cycle per grant
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            out_valid <= '0;
        else
        begin
            for (int o = 0; o < noc_pkg::num_ports; o++)
                out_valid[o] <= |out_grant[o];
        end
    end

    // Flit loads only on a grant, stale otherwise
    always_ff @(posedge clk)
    begin
        for (int o = 0; o < noc_pkg::num_ports; o++)
        begin
            if (|out_grant[o])
                out_flit[o] <= sel_flit[o];
        end
    end

    // A head goes to exactly one output
    a_single_output: assert property (@(posedge clk) disable iff (rst_n)
        multi_grant == '0);

endmodule
